// ==== hw/mdio_data_capture.sv ====
/*
 * MDIO data capture: shifts the 16 data bits from both lines and hands
 * the completed frame word to the result stage
 */
`timescale 1ns/1ps
`default_nettype none

module mdio_data_capture (
  input  logic                     mdio_mdc,
  input  logic                     rst_n,
  input  logic                     mdio_in_w,
  input  logic                     mdio_in_r,
  input  logic                     data_phase,
  input  logic                     frame_done,
  input  mdio_snoop_pkg::mdio_op_t frame_op,
  input  logic [4:0]               frame_phy_ad,
  input  logic [4:0]               frame_reg_ad,
  output logic                     word_valid,
  output mdio_snoop_pkg::mdio_op_t word_op,
  output logic [4:0]               word_phy_ad,
  output logic [4:0]               word_reg_ad,
  output logic [15:0]              word_data
);

  // Data field as seen on each line
  logic [mdio_snoop_pkg::data_bits-1:0] rd_sr;
  logic [mdio_snoop_pkg::data_bits-1:0] wr_sr;

  // ********************
  // Data shifting
  // ********************

  // The PHY drives the read line after the rising edge, so the falling
  // edge sees each bit in the middle of its cycle
  always_ff @(negedge mdio_mdc) begin
    if (data_phase) begin
      rd_sr <= {rd_sr[mdio_snoop_pkg::data_bits-2:0], mdio_in_r};
    end
  end

  // Station driven data is taken on the same edge as the header bits
  always_ff @(posedge mdio_mdc) begin
    if (data_phase) begin
      wr_sr <= {wr_sr[mdio_snoop_pkg::data_bits-2:0], mdio_in_w};
    end
  end

  // ********************
  // Word hand-off
  // ********************

  always_ff @(posedge mdio_mdc) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= frame_done;
    end
  end

  // Both shift registers are idle by now, the decoder already left the
  // data phase one cycle before frame_done
  always_ff @(posedge mdio_mdc) begin
    if (frame_done) begin
      word_op     <= frame_op;
      word_phy_ad <= frame_phy_ad;
      word_reg_ad <= frame_reg_ad;
      // Reads carry the PHY data, everything else the station data
      if (frame_op == mdio_snoop_pkg::op_read) begin
        word_data <= rd_sr;
      end else begin
        word_data <= wr_sr;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mdio_frame_decode.sv ====
/*
 * MDIO frame decode: finds the preamble on the station line, walks the
 * Clause 22 frame and captures the opcode and address fields
 */
`timescale 1ns/1ps
`default_nettype none

module mdio_frame_decode (
  input  logic                     mdio_mdc,
  input  logic                     rst_n,
  input  logic                     mdio_in_w,
  output logic                     data_phase,
  output logic                     frame_done,
  output mdio_snoop_pkg::mdio_op_t frame_op,
  output logic [4:0]               frame_phy_ad,
  output logic [4:0]               frame_reg_ad
);

  // Frame state and the bit position inside the current phase
  mdio_snoop_pkg::decode_state_t state;
  logic [4:0] bit_cnt;

  // Saturating count of consecutive ones seen while idle
  logic [5:0] ones_cnt;
  logic       armed;

  // Header bits collected so far, the newest one comes straight from the line
  logic [mdio_snoop_pkg::header_bits-2:0] hdr_sr;
  logic [mdio_snoop_pkg::header_bits-1:0] hdr_word;

  // Set on the edge that samples the last data bit, frame_done follows it
  logic data_last;

  assign armed      = (ones_cnt == 6'(mdio_snoop_pkg::preamble_len));
  assign hdr_word   = {hdr_sr, mdio_in_w};
  // The data bit on the line belongs to the frame for the whole cycle
  assign data_phase = (state == mdio_snoop_pkg::st_data);

  // ********************
  // Preamble detection
  // ********************

  always_ff @(posedge mdio_mdc) begin
    if (!rst_n) begin
      ones_cnt <= '0;
    end else if (state != mdio_snoop_pkg::st_idle || !mdio_in_w) begin
      // Any zero or any frame activity restarts the preamble search
      ones_cnt <= '0;
    end else if (!armed) begin
      ones_cnt <= ones_cnt + 6'd1;
    end
  end

  // ********************
  // Frame state machine
  // ********************

  always_ff @(posedge mdio_mdc) begin
    if (!rst_n) begin
      state      <= mdio_snoop_pkg::st_idle;
      bit_cnt    <= '0;
      data_last  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      data_last  <= 1'b0;
      frame_done <= data_last;
      case (state)
        mdio_snoop_pkg::st_idle: begin
          bit_cnt <= '0;
          // A zero after a full preamble is the first start bit
          if (armed && !mdio_in_w) begin
            state <= mdio_snoop_pkg::st_header;
          end
        end
        mdio_snoop_pkg::st_header: begin
          if (bit_cnt == 5'd0 && !mdio_in_w) begin
            // Second start bit must be one, otherwise this is not Clause 22
            state <= mdio_snoop_pkg::st_idle;
          end else if (bit_cnt == 5'(mdio_snoop_pkg::header_bits - 1)) begin
            state   <= mdio_snoop_pkg::st_turnaround;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 5'd1;
          end
        end
        mdio_snoop_pkg::st_turnaround: begin
          if (bit_cnt == 5'(mdio_snoop_pkg::ta_bits - 1)) begin
            state   <= mdio_snoop_pkg::st_data;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 5'd1;
          end
        end
        mdio_snoop_pkg::st_data: begin
          if (bit_cnt == 5'(mdio_snoop_pkg::data_bits - 1)) begin
            // Back to idle at once so a following preamble is not missed
            state     <= mdio_snoop_pkg::st_idle;
            bit_cnt   <= '0;
            data_last <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 5'd1;
          end
        end
        default: begin
          state <= mdio_snoop_pkg::st_idle;
        end
      endcase
    end
  end

  // ********************
  // Header field capture
  // ********************

  // Fields only change when a header completes, so they stay valid
  // through the data phase and until the next header ends
  always_ff @(posedge mdio_mdc) begin
    if (state == mdio_snoop_pkg::st_header) begin
      hdr_sr <= hdr_word[mdio_snoop_pkg::header_bits-2:0];
      if (bit_cnt == 5'(mdio_snoop_pkg::header_bits - 1)) begin
        // Word layout is start2, op[1:0], phy_ad[4:0], reg_ad[4:0]
        case (hdr_word[11:10])
          2'b01:   frame_op <= mdio_snoop_pkg::op_write;
          2'b10:   frame_op <= mdio_snoop_pkg::op_read;
          default: frame_op <= mdio_snoop_pkg::op_invalid;
        endcase
        frame_phy_ad <= hdr_word[9:5];
        frame_reg_ad <= hdr_word[4:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mdio_link_status.sv ====
/*
 * MDIO link status: filters completed frames, holds speed and duplex,
 * counts frames and serves the registers on a Wishbone classic slave
 */
`timescale 1ns/1ps
`default_nettype none

module mdio_link_status (
  input  logic                     mdio_mdc,
  input  logic                     rst_n,
  input  logic                     word_valid,
  input  mdio_snoop_pkg::mdio_op_t word_op,
  input  logic [4:0]               word_phy_ad,
  input  logic [4:0]               word_reg_ad,
  input  logic [15:0]              word_data,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [1:0]               wb_adr,
  input  logic [31:0]              wb_dat_w,
  output logic [31:0]              wb_dat_r,
  output logic                     wb_ack,
  output logic [1:0]               speed_select,
  output logic                     duplex_mode,
  output logic                     status_valid
);

  // PHY address whose status reads are tracked
  logic [4:0]  phy_filter;
  logic [15:0] frame_count;
  logic [15:0] match_count;

  logic        word_match;
  logic        wb_req;

  // A match is a status register read from the watched PHY
  assign word_match = word_valid &&
                      (word_op == mdio_snoop_pkg::op_read) &&
                      (word_phy_ad == phy_filter) &&
                      (word_reg_ad == mdio_snoop_pkg::reg_phy_status);

  // New request, not yet acked in the previous cycle
  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  // ********************
  // Link status and counters
  // ********************

  always_ff @(posedge mdio_mdc) begin
    if (!rst_n) begin
      speed_select <= 2'b00;
      duplex_mode  <= 1'b0;
      status_valid <= 1'b0;
      frame_count  <= '0;
      match_count  <= '0;
    end else begin
      if (word_valid) begin
        frame_count <= frame_count + 16'd1;
      end
      if (word_match) begin
        match_count  <= match_count + 16'd1;
        speed_select <= word_data[mdio_snoop_pkg::speed_msb:mdio_snoop_pkg::speed_lsb];
        duplex_mode  <= word_data[mdio_snoop_pkg::duplex_bit];
        status_valid <= 1'b1;
      end
    end
  end

  // ********************
  // Wishbone slave
  // ********************

  // Ack is a single pulse and drops for a cycle between held requests
  always_ff @(posedge mdio_mdc) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

  // Only the filter is writable, writes elsewhere are dropped
  always_ff @(posedge mdio_mdc) begin
    if (!rst_n) begin
      phy_filter <= mdio_snoop_pkg::phy_ad_default;
    end else if (wb_req && wb_we && wb_adr == mdio_snoop_pkg::wb_adr_phy_filter) begin
      phy_filter <= wb_dat_w[4:0];
    end
  end

  // Read data is registered with the ack, so a counter that steps on
  // the same edge is returned with its old value
  always_ff @(posedge mdio_mdc) begin
    if (wb_req) begin
      case (wb_adr)
        mdio_snoop_pkg::wb_adr_status: begin
          wb_dat_r <= {28'd0, status_valid, duplex_mode, speed_select};
        end
        mdio_snoop_pkg::wb_adr_phy_filter: begin
          wb_dat_r <= {27'd0, phy_filter};
        end
        mdio_snoop_pkg::wb_adr_frame_count: begin
          wb_dat_r <= {16'd0, frame_count};
        end
        default: begin
          wb_dat_r <= {16'd0, match_count};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/mdio_snoop_pkg.sv ====
/*
 * MDIO snoop shared definitions: Clause 22 frame fields, link status
 * bit positions, Wishbone register map and the state and opcode types
 */
`default_nettype none

package mdio_snoop_pkg;

  // ********************
  // Frame geometry
  // ********************

  // Consecutive ones on the station line that arm the decoder
  localparam int unsigned preamble_len = 32;
  // Second start bit, opcode, PHY address and register address
  localparam int unsigned header_bits  = 13;
  // Turnaround cycles between the header and the data field
  localparam int unsigned ta_bits      = 2;
  // Width of the data field
  localparam int unsigned data_bits    = 16;

  // ********************
  // Watched PHY register
  // ********************

  // Reset value of the writable PHY address filter
  localparam logic [4:0] phy_ad_default = 5'b10000;
  // PHY-specific status register that reports the resolved link
  localparam logic [4:0] reg_phy_status = 5'h11;

  // Positions of the link fields inside the status register data
  localparam int unsigned speed_msb  = 15;
  localparam int unsigned speed_lsb  = 14;
  localparam int unsigned duplex_bit = 13;

  // ********************
  // Register map
  // ********************

  // Word addresses seen on the Wishbone slave
  localparam logic [1:0] wb_adr_status      = 2'd0;
  localparam logic [1:0] wb_adr_phy_filter  = 2'd1;
  localparam logic [1:0] wb_adr_frame_count = 2'd2;
  localparam logic [1:0] wb_adr_match_count = 2'd3;

  // Clause 22 opcodes, the two unused codes fold into op_invalid
  typedef enum logic [1:0] {
    op_invalid = 2'b00,
    op_write   = 2'b01,
    op_read    = 2'b10
  } mdio_op_t;

  // Decode stage frame states
  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_header     = 2'd1,
    st_turnaround = 2'd2,
    st_data       = 2'd3
  } decode_state_t;

endpackage

`default_nettype wire

// ==== hw/mdio_snoop_top.sv ====
/*
 * MDIO snoop top level: decode, execute and result stages in a chain
 */
`timescale 1ns/1ps
`default_nettype none

module mdio_snoop_top (
  input  logic        mdio_mdc,
  input  logic        rst_n,
  input  logic        mdio_in_w,
  input  logic        mdio_in_r,
  output logic [1:0]  speed_select,
  output logic        duplex_mode,
  output logic        status_valid,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  // Decode to execute
  logic                     data_phase;
  logic                     frame_done;
  mdio_snoop_pkg::mdio_op_t frame_op;
  logic [4:0]               frame_phy_ad;
  logic [4:0]               frame_reg_ad;

  // Execute to result
  logic                     word_valid;
  mdio_snoop_pkg::mdio_op_t word_op;
  logic [4:0]               word_phy_ad;
  logic [4:0]               word_reg_ad;
  logic [15:0]              word_data;

  mdio_frame_decode u_decode (
    .mdio_mdc     (mdio_mdc),
    .rst_n        (rst_n),
    .mdio_in_w    (mdio_in_w),
    .data_phase   (data_phase),
    .frame_done   (frame_done),
    .frame_op     (frame_op),
    .frame_phy_ad (frame_phy_ad),
    .frame_reg_ad (frame_reg_ad)
  );

  mdio_data_capture u_capture (
    .mdio_mdc     (mdio_mdc),
    .rst_n        (rst_n),
    .mdio_in_w    (mdio_in_w),
    .mdio_in_r    (mdio_in_r),
    .data_phase   (data_phase),
    .frame_done   (frame_done),
    .frame_op     (frame_op),
    .frame_phy_ad (frame_phy_ad),
    .frame_reg_ad (frame_reg_ad),
    .word_valid   (word_valid),
    .word_op      (word_op),
    .word_phy_ad  (word_phy_ad),
    .word_reg_ad  (word_reg_ad),
    .word_data    (word_data)
  );

  mdio_link_status u_status (
    .mdio_mdc     (mdio_mdc),
    .rst_n        (rst_n),
    .word_valid   (word_valid),
    .word_op      (word_op),
    .word_phy_ad  (word_phy_ad),
    .word_reg_ad  (word_reg_ad),
    .word_data    (word_data),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .speed_select (speed_select),
    .duplex_mode  (duplex_mode),
    .status_valid (status_valid)
  );

endmodule

`default_nettype wire

// ==== mdio_snoop.f ====
hw/mdio_snoop_pkg.sv
hw/mdio_frame_decode.sv
hw/mdio_data_capture.sv
hw/mdio_link_status.sv
hw/mdio_snoop_top.sv
test/mdio_frame_driver.sv
test/tb_mdio_snoop.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the MDIO snoop testbench with Verilator and runs it into sim.log.
# The exit status comes from searching the log for the fail message.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_mdio_snoop -f mdio_snoop.f \
  -o tb_mdio_snoop || { echo "Build failed"; exit 1; }

./obj_dir/tb_mdio_snoop > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

// ==== test/mdio_frame_driver.sv ====
/*
 * MDIO frame driver: emits Clause 22 frames on the station line and
 * the PHY read line, changing both only at the rising clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module mdio_frame_driver (
  input  logic mdio_mdc,
  output logic mdio_in_w,
  output logic mdio_in_r
);

  // Station line starts low so no preamble is counted before the first frame
  initial begin
    mdio_in_w <= 1'b0;
    mdio_in_r <= 1'b1;
  end

  // One bit time on both lines, held until the next rising edge
  task automatic drive_bit(input logic w_bit, input logic r_bit);
    @(posedge mdio_mdc);
    mdio_in_w <= w_bit;
    mdio_in_r <= r_bit;
  endtask

  // Quiet bus with the station line low, which restarts the preamble search
  task automatic idle(input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      drive_bit(1'b0, 1'b1);
    end
  endtask

  // ********************
  // Clause 22 frame
  // ********************

  task automatic send_frame(
    input int                       pre_len,
    input mdio_snoop_pkg::mdio_op_t op,
    input logic [4:0]               phy_ad,
    input logic [4:0]               reg_ad,
    input logic [15:0]              data
  );
    logic [13:0] header;
    int          i;
    // Start bits 01, opcode, PHY address and register address, MSB first
    header = {2'b01, op, phy_ad, reg_ad};
    for (i = 0; i < pre_len; i++) begin
      drive_bit(1'b1, 1'b1);
    end
    for (i = 13; i >= 0; i--) begin
      drive_bit(header[i], 1'b1);
    end
    if (op == mdio_snoop_pkg::op_read) begin
      // Station releases its line, the PHY pulls the read line low in the second turnaround bit
      drive_bit(1'b1, 1'b1);
      drive_bit(1'b1, 1'b0);
      for (i = 15; i >= 0; i--) begin
        drive_bit(1'b1, data[i]);
      end
    end else begin
      // Write turnaround is 10, then the station drives the data itself
      drive_bit(1'b1, 1'b1);
      drive_bit(1'b0, 1'b1);
      for (i = 15; i >= 0; i--) begin
        drive_bit(data[i], 1'b1);
      end
    end
  endtask

endmodule

`default_nettype wire

// ==== test/tb_mdio_snoop.sv ====
/*
 * MDIO snoop testbench: drives Clause 22 frames and Wishbone accesses
 * and checks link status, filter and counters against a scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mdio_snoop;

  logic        mdio_mdc;
  logic        rst_n;
  logic        mdio_in_w;
  logic        mdio_in_r;
  logic [1:0]  speed_select;
  logic        duplex_mode;
  logic        status_valid;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  // Scoreboard state
  logic [1:0]  exp_speed;
  logic        exp_duplex;
  logic        exp_valid;
  logic [4:0]  exp_filter;
  logic [15:0] exp_frames;
  logic [15:0] exp_matches;
  logic [31:0] lfsr_state;

  mdio_snoop_top DUT (
    .mdio_mdc     (mdio_mdc),
    .rst_n        (rst_n),
    .mdio_in_w    (mdio_in_w),
    .mdio_in_r    (mdio_in_r),
    .speed_select (speed_select),
    .duplex_mode  (duplex_mode),
    .status_valid (status_valid),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack)
  );

  mdio_frame_driver u_driver (
    .mdio_mdc  (mdio_mdc),
    .mdio_in_w (mdio_in_w),
    .mdio_in_r (mdio_in_r)
  );

  initial begin
    mdio_mdc = 1'b0;
    forever #2 mdio_mdc = ~mdio_mdc;
  end

  // ********************
  // Helpers
  // ********************

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      report_failure($sformatf("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                               $time, name, expected, actual));
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1, the new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] random_data();
    logic [15:0] w;
    int          i;
    w = '0;
    for (i = 0; i < 16; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[14:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // One classic cycle; ack is expected one cycle after the request and only once
  task automatic wb_transfer(input logic we, input logic [1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(posedge mdio_mdc);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    @(posedge mdio_mdc);
    while (!wb_ack && waited < 16) begin
      waited++;
      @(posedge mdio_mdc);
    end
    if (!wb_ack) begin
      report_failure("Timeout: no wb_ack for a Wishbone transfer");
    end else begin
      rdata = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      check_value("wb_ack latency", 32'd1, 32'(waited));
      @(posedge mdio_mdc);
      check_value("wb_ack after pulse", 32'd0, {31'd0, wb_ack});
    end
  endtask

  // Scoreboard update for one completed frame
  task automatic record_frame(input mdio_snoop_pkg::mdio_op_t op, input logic [4:0] phy_ad,
                              input logic [4:0] reg_ad, input logic [15:0] data);
    exp_frames = exp_frames + 16'd1;
    if (op == mdio_snoop_pkg::op_read && phy_ad == exp_filter &&
        reg_ad == mdio_snoop_pkg::reg_phy_status) begin
      exp_matches = exp_matches + 16'd1;
      exp_speed   = data[mdio_snoop_pkg::speed_msb:mdio_snoop_pkg::speed_lsb];
      exp_duplex  = data[mdio_snoop_pkg::duplex_bit];
      exp_valid   = 1'b1;
    end
  endtask

  // Polls frame_count until it reaches the scoreboard, then checks everything
  task automatic check_all();
    logic [31:0] rdata;
    int          tries;
    tries = 0;
    wb_transfer(1'b0, mdio_snoop_pkg::wb_adr_frame_count, 32'd0, rdata);
    while (rdata[15:0] < exp_frames && tries < 40) begin
      tries++;
      wb_transfer(1'b0, mdio_snoop_pkg::wb_adr_frame_count, 32'd0, rdata);
    end
    if (rdata[15:0] < exp_frames) begin
      report_failure("Timeout: frame_count never reached the expected value");
    end else begin
      check_value("frame_count", {16'd0, exp_frames}, rdata);
      check_value("speed_select", {30'd0, exp_speed}, {30'd0, speed_select});
      check_value("duplex_mode", {31'd0, exp_duplex}, {31'd0, duplex_mode});
      check_value("status_valid", {31'd0, exp_valid}, {31'd0, status_valid});
      wb_transfer(1'b0, mdio_snoop_pkg::wb_adr_status, 32'd0, rdata);
      check_value("wb status word", {28'd0, exp_valid, exp_duplex, exp_speed}, rdata);
      wb_transfer(1'b0, mdio_snoop_pkg::wb_adr_phy_filter, 32'd0, rdata);
      check_value("phy_filter", {27'd0, exp_filter}, rdata);
      wb_transfer(1'b0, mdio_snoop_pkg::wb_adr_match_count, 32'd0, rdata);
      check_value("match_count", {16'd0, exp_matches}, rdata);
    end
  endtask

  task automatic send_and_check(input mdio_snoop_pkg::mdio_op_t op, input logic [4:0] phy_ad,
                                input logic [4:0] reg_ad, input logic [15:0] data);
    u_driver.send_frame(32, op, phy_ad, reg_ad, data);
    record_frame(op, phy_ad, reg_ad, data);
    check_all();
  endtask

  // ********************
  // Scenarios
  // ********************

  initial begin
    logic [15:0] burst_data [0:5];
    logic [31:0] rdata;
    int          k;
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= 2'd0;
    wb_dat_w <= 32'd0;
    lfsr_state  = 32'h4ff9f38e;
    exp_speed   = 2'b00;
    exp_duplex  = 1'b0;
    exp_valid   = 1'b0;
    exp_filter  = mdio_snoop_pkg::phy_ad_default;
    exp_frames  = 16'd0;
    exp_matches = 16'd0;
    repeat (16) @(posedge mdio_mdc);
    rst_n <= 1'b1;

    // Reset values on the pins and in every register
    check_all();

    // Back to back status reads, each checked while the next frame is on the wire
    for (k = 0; k < 6; k++) begin
      burst_data[k] = random_data();
    end
    u_driver.send_frame(32, mdio_snoop_pkg::op_read, exp_filter,
                        mdio_snoop_pkg::reg_phy_status, burst_data[0]);
    for (k = 0; k < 6; k++) begin
      fork
        begin
          if (k < 5) begin
            u_driver.send_frame(32, mdio_snoop_pkg::op_read, exp_filter,
                                mdio_snoop_pkg::reg_phy_status, burst_data[k + 1]);
          end
        end
        begin
          record_frame(mdio_snoop_pkg::op_read, exp_filter,
                       mdio_snoop_pkg::reg_phy_status, burst_data[k]);
          check_all();
        end
      join
    end

    // Other PHY, other register and a write all miss the filter
    send_and_check(mdio_snoop_pkg::op_read, exp_filter ^ 5'h01,
                   mdio_snoop_pkg::reg_phy_status, random_data());
    send_and_check(mdio_snoop_pkg::op_read, exp_filter, 5'h01, random_data());
    send_and_check(mdio_snoop_pkg::op_write, exp_filter,
                   mdio_snoop_pkg::reg_phy_status, random_data());

    // Only bits 4:0 of the written word land in the filter
    wb_transfer(1'b1, mdio_snoop_pkg::wb_adr_phy_filter, 32'hA5A5_A5E3, rdata);
    exp_filter = 5'h03;
    check_all();
    send_and_check(mdio_snoop_pkg::op_read, mdio_snoop_pkg::phy_ad_default,
                   mdio_snoop_pkg::reg_phy_status, random_data());
    send_and_check(mdio_snoop_pkg::op_read, 5'h03, mdio_snoop_pkg::reg_phy_status,
                   random_data());

    // Twenty ones never arm the decoder, the frame after it decodes normally
    u_driver.idle(4);
    u_driver.send_frame(20, mdio_snoop_pkg::op_read, exp_filter,
                        mdio_snoop_pkg::reg_phy_status, random_data());
    u_driver.idle(8);
    check_all();
    send_and_check(mdio_snoop_pkg::op_read, exp_filter, mdio_snoop_pkg::reg_phy_status,
                   random_data());

    // Counter writes are dropped
    wb_transfer(1'b1, mdio_snoop_pkg::wb_adr_frame_count, 32'hFFFF_FFFF, rdata);
    wb_transfer(1'b1, mdio_snoop_pkg::wb_adr_match_count, 32'h0000_1234, rdata);
    check_all();

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
